// File: decode_pkg.sv
`default_nettype none

package decode_pkg;

   //////////////////////////////////////////////////////////////////////
   // Field and control word widths
   //////////////////////////////////////////////////////////////////////
   localparam int NB_INSTR    = 32;
   localparam int NB_OPCODE   = 6;
   localparam int NB_FUNCT    = 6;
   localparam int NB_REG_ADDR = 5;
   localparam int NB_IMM      = 16;
   localparam int NB_SHAMT    = 5;
   localparam int NB_J_ADDR   = 26;
   localparam int NB_ALUOP    = 4;
   localparam int NB_DSIZE    = 2;
   localparam int NB_EX       = NB_ALUOP + 2;
   localparam int NB_MEM      = NB_DSIZE + 3;
   localparam int NB_WB       = NB_REG_ADDR + 3;

   // Opcodes
   localparam logic [NB_OPCODE-1:0] OP_R_TYPE = 6'b000000;
   localparam logic [NB_OPCODE-1:0] OP_LB     = 6'b100000;
   localparam logic [NB_OPCODE-1:0] OP_LH     = 6'b100001;
   localparam logic [NB_OPCODE-1:0] OP_LW     = 6'b100011;
   localparam logic [NB_OPCODE-1:0] OP_LBU    = 6'b100100;
   localparam logic [NB_OPCODE-1:0] OP_LHU    = 6'b100101;
   localparam logic [NB_OPCODE-1:0] OP_LWU    = 6'b100111;
   localparam logic [NB_OPCODE-1:0] OP_SB     = 6'b101000;
   localparam logic [NB_OPCODE-1:0] OP_SH     = 6'b101001;
   localparam logic [NB_OPCODE-1:0] OP_SW     = 6'b101011;
   localparam logic [NB_OPCODE-1:0] OP_ADDI   = 6'b001001;
   localparam logic [NB_OPCODE-1:0] OP_ANDI   = 6'b001100;
   localparam logic [NB_OPCODE-1:0] OP_ORI    = 6'b001101;
   localparam logic [NB_OPCODE-1:0] OP_XORI   = 6'b001110;
   localparam logic [NB_OPCODE-1:0] OP_LUI    = 6'b001111;
   localparam logic [NB_OPCODE-1:0] OP_SLTI   = 6'b001010;
   localparam logic [NB_OPCODE-1:0] OP_BEQ    = 6'b000100;
   localparam logic [NB_OPCODE-1:0] OP_BNE    = 6'b000101;
   localparam logic [NB_OPCODE-1:0] OP_J      = 6'b000010;
   localparam logic [NB_OPCODE-1:0] OP_JAL    = 6'b000011;

   // R-type funct codes
   localparam logic [NB_FUNCT-1:0] FUNCT_SLL  = 6'b000000;
   localparam logic [NB_FUNCT-1:0] FUNCT_SRL  = 6'b000010;
   localparam logic [NB_FUNCT-1:0] FUNCT_SRA  = 6'b000011;
   localparam logic [NB_FUNCT-1:0] FUNCT_SLLV = 6'b000100;
   localparam logic [NB_FUNCT-1:0] FUNCT_SRLV = 6'b000110;
   localparam logic [NB_FUNCT-1:0] FUNCT_SRAV = 6'b000111;
   localparam logic [NB_FUNCT-1:0] FUNCT_JR   = 6'b001000;
   localparam logic [NB_FUNCT-1:0] FUNCT_JALR = 6'b001001;
   localparam logic [NB_FUNCT-1:0] FUNCT_ADDU = 6'b100001;
   localparam logic [NB_FUNCT-1:0] FUNCT_SUBU = 6'b100011;
   localparam logic [NB_FUNCT-1:0] FUNCT_AND  = 6'b100100;
   localparam logic [NB_FUNCT-1:0] FUNCT_OR   = 6'b100101;
   localparam logic [NB_FUNCT-1:0] FUNCT_XOR  = 6'b100110;
   localparam logic [NB_FUNCT-1:0] FUNCT_NOR  = 6'b100111;
   localparam logic [NB_FUNCT-1:0] FUNCT_SLT  = 6'b101010;

   // ALU operations
   localparam logic [NB_ALUOP-1:0] ALU_ADD = 4'd0;
   localparam logic [NB_ALUOP-1:0] ALU_SUB = 4'd1;
   localparam logic [NB_ALUOP-1:0] ALU_AND = 4'd2;
   localparam logic [NB_ALUOP-1:0] ALU_OR  = 4'd3;
   localparam logic [NB_ALUOP-1:0] ALU_XOR = 4'd4;
   localparam logic [NB_ALUOP-1:0] ALU_NOR = 4'd5;
   localparam logic [NB_ALUOP-1:0] ALU_SRL = 4'd6;
   localparam logic [NB_ALUOP-1:0] ALU_SLL = 4'd7;
   localparam logic [NB_ALUOP-1:0] ALU_SRA = 4'd8;
   localparam logic [NB_ALUOP-1:0] ALU_SLA = 4'd9;
   localparam logic [NB_ALUOP-1:0] ALU_SLT = 4'd10;
   localparam logic [NB_ALUOP-1:0] ALU_LUI = 4'd11;

   localparam logic [NB_DSIZE-1:0] DSIZE_BYTE = 2'd0;
   localparam logic [NB_DSIZE-1:0] DSIZE_HALF = 2'd1;
   localparam logic [NB_DSIZE-1:0] DSIZE_WORD = 2'd2;

   // Return address register for JAL/JALR
   localparam logic [NB_REG_ADDR-1:0] LINK_REG_ADDR = 5'd31;

   //////////////////////////////////////////////////////////////////////
   // Control word bit positions
   //////////////////////////////////////////////////////////////////////
   localparam int EX_ALUOP_LSB  = 2;
   localparam int EX_B_I        = 1;
   localparam int EX_UNSIGNED   = 0;
   localparam int MEM_RD_EN     = 4;
   localparam int MEM_WR_EN     = 3;
   localparam int MEM_UNSIGNED  = 2;
   localparam int MEM_DSIZE_LSB = 0;
   localparam int WB_DEST_LSB   = 3;
   localparam int WB_REG_WE     = 2;
   localparam int WB_MEM_ALU    = 1;
   localparam int WB_DATA_PC    = 0;

   // Same instruction word seen as R, I or J format
   typedef union packed {
      struct packed {
         logic [NB_OPCODE-1:0]   opcode;
         logic [NB_REG_ADDR-1:0] rs;
         logic [NB_REG_ADDR-1:0] rt;
         logic [NB_REG_ADDR-1:0] rd;
         logic [NB_SHAMT-1:0]    shamt;
         logic [NB_FUNCT-1:0]    funct;
      } r;
      struct packed {
         logic [NB_OPCODE-1:0]   opcode;
         logic [NB_REG_ADDR-1:0] rs;
         logic [NB_REG_ADDR-1:0] rt;
         logic [NB_IMM-1:0]      imm;
      } i;
      struct packed {
         logic [NB_OPCODE-1:0]   opcode;
         logic [NB_J_ADDR-1:0]   target;
      } j;
   } instr_u;

endpackage

`default_nettype wire

// File: funct_decoder.sv
`default_nettype none

module funct_decoder (
   input  logic [decode_pkg::NB_FUNCT-1:0] i_funct,
   output logic [decode_pkg::NB_ALUOP-1:0] o_aluop,
   output logic                            o_link,
   output logic                            o_jump_reg
);

   import decode_pkg::*;

   // Second level lookup, only meaningful under the R-type opcode
   always_comb begin
      o_aluop    = ALU_ADD;
      o_link     = 1'b0;
      o_jump_reg = 1'b0;
      case (i_funct)
         FUNCT_SLL,
         FUNCT_SLLV: o_aluop = ALU_SLL;
         FUNCT_SRL,
         FUNCT_SRLV: o_aluop = ALU_SRL;
         FUNCT_SRA,
         FUNCT_SRAV: o_aluop = ALU_SRA;
         FUNCT_ADDU: o_aluop = ALU_ADD;
         FUNCT_SUBU: o_aluop = ALU_SUB;
         FUNCT_AND:  o_aluop = ALU_AND;
         FUNCT_OR:   o_aluop = ALU_OR;
         FUNCT_XOR:  o_aluop = ALU_XOR;
         FUNCT_NOR:  o_aluop = ALU_NOR;
         FUNCT_SLT:  o_aluop = ALU_SLT;
         FUNCT_JR: begin
            o_jump_reg = 1'b1;
         end
         FUNCT_JALR: begin
            o_jump_reg = 1'b1;
            // Return address goes to the link register
            o_link     = 1'b1;
         end
         default: o_aluop = ALU_ADD;
      endcase
   end

endmodule

`default_nettype wire

// File: control_decoder.sv
`default_nettype none

module control_decoder (
   input  decode_pkg::instr_u              i_instruction,
   output logic [decode_pkg::NB_EX-1:0]    o_ex_ctrl,
   output logic [decode_pkg::NB_MEM-1:0]   o_mem_ctrl,
   output logic [decode_pkg::NB_WB-1:0]    o_wb_ctrl,
   output logic                            o_is_branch,
   output logic                            o_branch_ne,
   output logic                            o_jump_imm,
   output logic                            o_jump_reg
);

   import decode_pkg::*;

   logic [NB_OPCODE-1:0]   opcode;
   logic [NB_ALUOP-1:0]    f_aluop;
   logic                   f_link;
   logic                   f_jump_reg;
   logic                   is_rtype;
   logic [NB_ALUOP-1:0]    aluop_main;
   logic [NB_ALUOP-1:0]    aluop;
   logic                   b_i;
   logic                   s_u_ex;
   logic                   rd_en;
   logic                   wr_en;
   logic                   s_u_mem;
   logic [NB_DSIZE-1:0]    dsize;
   logic                   reg_we;
   logic                   mem_alu;
   logic                   link_main;
   logic                   data_pc;
   logic [NB_REG_ADDR-1:0] dest;

   assign opcode = i_instruction.r.opcode;

   funct_decoder funct_decoder_inst (
      .i_funct    (i_instruction.r.funct),
      .o_aluop    (f_aluop),
      .o_link     (f_link),
      .o_jump_reg (f_jump_reg)
   );

   //////////////////////////////////////////////////////////////////////
   // Main opcode lookup
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      is_rtype    = 1'b0;
      aluop_main  = ALU_ADD;
      b_i         = 1'b0;
      s_u_ex      = 1'b0;
      rd_en       = 1'b0;
      wr_en       = 1'b0;
      s_u_mem     = 1'b0;
      dsize       = DSIZE_BYTE;
      reg_we      = 1'b0;
      mem_alu     = 1'b0;
      link_main   = 1'b0;
      o_is_branch = 1'b0;
      o_branch_ne = 1'b0;
      o_jump_imm  = 1'b0;
      case (opcode)
         OP_R_TYPE: begin
            is_rtype = 1'b1;
            reg_we   = 1'b1;
            mem_alu  = 1'b1;
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU,
         OP_SB, OP_SH, OP_SW: begin
            b_i     = 1'b1;
            rd_en   = !opcode[3];
            wr_en   = opcode[3];
            reg_we  = !opcode[3];
            s_u_mem = opcode inside {OP_LBU, OP_LHU, OP_LWU};
            // Low opcode bits give the access size
            case (opcode[1:0])
               2'b00:   dsize = DSIZE_BYTE;
               2'b01:   dsize = DSIZE_HALF;
               default: dsize = DSIZE_WORD;
            endcase
         end
         OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI: begin
            b_i     = 1'b1;
            reg_we  = 1'b1;
            mem_alu = 1'b1;
            s_u_ex  = opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
            case (opcode)
               OP_ANDI: aluop_main = ALU_AND;
               OP_ORI:  aluop_main = ALU_OR;
               OP_XORI: aluop_main = ALU_XOR;
               OP_LUI:  aluop_main = ALU_LUI;
               OP_SLTI: aluop_main = ALU_SLT;
               default: aluop_main = ALU_ADD;
            endcase
         end
         OP_BEQ, OP_BNE: begin
            b_i         = 1'b1;
            o_is_branch = 1'b1;
            o_branch_ne = (opcode == OP_BNE);
         end
         OP_J: begin
            o_jump_imm = 1'b1;
         end
         OP_JAL: begin
            o_jump_imm = 1'b1;
            reg_we     = 1'b1;
            link_main  = 1'b1;
         end
         default: is_rtype = 1'b0;
      endcase
   end

   // Funct result only counts under the R-type opcode
   assign aluop      = is_rtype ? f_aluop : aluop_main;
   assign data_pc    = is_rtype ? f_link : link_main;
   assign o_jump_reg = is_rtype & f_jump_reg;

   always_comb begin
      if (!reg_we)
         dest = '0;
      else if (data_pc)
         dest = LINK_REG_ADDR;
      else if (b_i)
         dest = i_instruction.i.rt;
      else
         dest = i_instruction.r.rd;
   end

   always_comb begin
      o_ex_ctrl                                 = '0;
      o_ex_ctrl[EX_ALUOP_LSB +: NB_ALUOP]       = aluop;
      o_ex_ctrl[EX_B_I]                         = b_i;
      o_ex_ctrl[EX_UNSIGNED]                    = s_u_ex;
      o_mem_ctrl                                = '0;
      o_mem_ctrl[MEM_RD_EN]                     = rd_en;
      o_mem_ctrl[MEM_WR_EN]                     = wr_en;
      o_mem_ctrl[MEM_UNSIGNED]                  = s_u_mem;
      o_mem_ctrl[MEM_DSIZE_LSB +: NB_DSIZE]     = dsize;
      o_wb_ctrl                                 = '0;
      o_wb_ctrl[WB_DEST_LSB +: NB_REG_ADDR]     = dest;
      o_wb_ctrl[WB_REG_WE]                      = reg_we;
      o_wb_ctrl[WB_MEM_ALU]                     = mem_alu;
      o_wb_ctrl[WB_DATA_PC]                     = data_pc;
   end

endmodule

`default_nettype wire

// File: branch_resolver.sv
`default_nettype none

module branch_resolver #(
   parameter int NB_DATA = 32
) (
   input  logic               i_is_branch,
   input  logic               i_branch_ne,
   input  logic               i_jump_imm,
   input  logic               i_jump_reg,
   input  logic [NB_DATA-1:0] i_rs_value,
   input  logic [NB_DATA-1:0] i_rt_value,
   output logic               o_flush_req
);

   logic operands_eq;
   logic branch_taken;

   assign operands_eq = (i_rs_value == i_rt_value);

   // BNE takes the inverted compare
   assign branch_taken = i_is_branch & (operands_eq ^ i_branch_ne);

   // Any taken control transfer kills the instruction behind it
   assign o_flush_req = branch_taken | i_jump_imm | i_jump_reg;

endmodule

`default_nettype wire

// File: id_ex_register.sv
`default_nettype none

module id_ex_register #(
   parameter int NB_PC = 32
) (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic [decode_pkg::NB_EX-1:0]  i_ex_ctrl,
   input  logic [decode_pkg::NB_MEM-1:0] i_mem_ctrl,
   input  logic [decode_pkg::NB_WB-1:0]  i_wb_ctrl,
   input  logic [NB_PC-1:0]              i_pc,
   input  logic                          i_flush_req,
   output logic [decode_pkg::NB_EX-1:0]  o_ex_ctrl,
   output logic [decode_pkg::NB_MEM-1:0] o_mem_ctrl,
   output logic [decode_pkg::NB_WB-1:0]  o_wb_ctrl,
   output logic [NB_PC-1:0]              o_pc,
   output logic                          o_flush
);

   // Control words, reset keeps memory enables low
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_ctrl  <= '0;
         o_mem_ctrl <= '0;
         o_wb_ctrl  <= '0;
         o_flush    <= 1'b0;
      end else begin
         o_ex_ctrl  <= i_ex_ctrl;
         o_mem_ctrl <= i_mem_ctrl;
         o_wb_ctrl  <= i_wb_ctrl;
         o_flush    <= i_flush_req;
      end
   end

   // PC
   always_ff @(posedge i_clk) begin
      if (i_rst)
         o_pc <= '0;
      else
         o_pc <= i_pc;
   end

endmodule

`default_nettype wire

// File: decode_stage.sv
`default_nettype none

module decode_stage #(
   parameter int NB_DATA = 32,
   parameter int NB_PC   = 32
) (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  logic [decode_pkg::NB_INSTR-1:0]  i_instruction,
   input  logic [NB_PC-1:0]                 i_pc,
   input  logic [NB_DATA-1:0]               i_rs_value,
   input  logic [NB_DATA-1:0]               i_rt_value,
   output logic [decode_pkg::NB_EX-1:0]     o_ex_ctrl,
   output logic [decode_pkg::NB_MEM-1:0]    o_mem_ctrl,
   output logic [decode_pkg::NB_WB-1:0]     o_wb_ctrl,
   output logic [NB_PC-1:0]                 o_pc,
   output logic                             o_flush,
   output logic                             o_branch,
   output logic                             o_jump_reg,
   output logic                             o_jump_imm,
   output logic [decode_pkg::NB_J_ADDR-1:0] o_jump_addr,
   output logic [decode_pkg::NB_IMM-1:0]    o_imm
);

   import decode_pkg::*;

   instr_u            instr;
   logic [NB_EX-1:0]  ex_ctrl;
   logic [NB_MEM-1:0] mem_ctrl;
   logic [NB_WB-1:0]  wb_ctrl;
   logic              branch_ne;
   logic              flush_req;

   assign instr = i_instruction;

   // Same-cycle fields for the fetch stage
   assign o_jump_addr = instr.j.target;
   assign o_imm       = instr.i.imm;

   control_decoder control_decoder_inst (
      .i_instruction (instr),
      .o_ex_ctrl     (ex_ctrl),
      .o_mem_ctrl    (mem_ctrl),
      .o_wb_ctrl     (wb_ctrl),
      .o_is_branch   (o_branch),
      .o_branch_ne   (branch_ne),
      .o_jump_imm    (o_jump_imm),
      .o_jump_reg    (o_jump_reg)
   );

   branch_resolver #(
      .NB_DATA (NB_DATA)
   ) branch_resolver_inst (
      .i_is_branch (o_branch),
      .i_branch_ne (branch_ne),
      .i_jump_imm  (o_jump_imm),
      .i_jump_reg  (o_jump_reg),
      .i_rs_value  (i_rs_value),
      .i_rt_value  (i_rt_value),
      .o_flush_req (flush_req)
   );

   id_ex_register #(
      .NB_PC (NB_PC)
   ) id_ex_register_inst (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ex_ctrl   (ex_ctrl),
      .i_mem_ctrl  (mem_ctrl),
      .i_wb_ctrl   (wb_ctrl),
      .i_pc        (i_pc),
      .i_flush_req (flush_req),
      .o_ex_ctrl   (o_ex_ctrl),
      .o_mem_ctrl  (o_mem_ctrl),
      .o_wb_ctrl   (o_wb_ctrl),
      .o_pc        (o_pc),
      .o_flush     (o_flush)
   );

endmodule

`default_nettype wire

// File: decode_props.sv
`default_nettype none

module decode_props (
   input logic                          i_clk,
   input logic                          i_rst,
   input logic [decode_pkg::NB_MEM-1:0] o_mem_ctrl,
   input logic                          o_flush,
   input logic                          o_jump_imm
);

   import decode_pkg::*;

   // A memory access is either a load or a store
   mem_enables_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
      !(o_mem_ctrl[MEM_RD_EN] && o_mem_ctrl[MEM_WR_EN]))
      else $error("MEM read and write enables set together");

   flush_low_after_reset: assert property (@(posedge i_clk) i_rst |=> !o_flush)
      else $error("o_flush high in the cycle after reset");

   jump_imm_flushes: assert property (@(posedge i_clk) disable iff (i_rst)
      o_jump_imm |=> o_flush)
      else $error("Immediate jump not followed by o_flush");

endmodule

bind decode_stage decode_props decode_props_inst (
   .i_clk      (i_clk),
   .i_rst      (i_rst),
   .o_mem_ctrl (o_mem_ctrl),
   .o_flush    (o_flush),
   .o_jump_imm (o_jump_imm)
);

`default_nettype wire

// File: tb_decode_stage.sv
`default_nettype none

module tb_decode_stage;

   import decode_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int NUM_TESTS  = 6;
   localparam int TIMEOUT    = 200 * NUM_TESTS * CLK_PERIOD;

   // Loads first, then stores
   localparam logic [NB_OPCODE-1:0] MEM_OPS [9] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
                                                    OP_LWU, OP_SB, OP_SH, OP_SW};
   localparam logic [1:0] MEM_SIZES [9] = '{DSIZE_BYTE, DSIZE_HALF, DSIZE_WORD, DSIZE_BYTE,
                                            DSIZE_HALF, DSIZE_WORD, DSIZE_BYTE, DSIZE_HALF,
                                            DSIZE_WORD};
   localparam logic [NB_FUNCT-1:0] R_FUNCTS [13] = '{FUNCT_SLL, FUNCT_SRL, FUNCT_SRA,
      FUNCT_SLLV, FUNCT_SRLV, FUNCT_SRAV, FUNCT_ADDU, FUNCT_SUBU, FUNCT_AND, FUNCT_OR,
      FUNCT_XOR, FUNCT_NOR, FUNCT_SLT};
   localparam logic [NB_ALUOP-1:0] R_ALUOPS [13] = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLL,
      ALU_SRL, ALU_SRA, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT};
   localparam logic [NB_OPCODE-1:0] I_OPS [6] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
                                                  OP_LUI, OP_SLTI};
   localparam logic [NB_ALUOP-1:0] I_ALUOPS [6] = '{ALU_ADD, ALU_AND, ALU_OR, ALU_XOR,
                                                    ALU_LUI, ALU_SLT};

   logic                   i_clk;
   logic                   i_rst;
   logic [NB_INSTR-1:0]    i_instruction;
   logic [31:0]            i_pc;
   logic [31:0]            i_rs_value;
   logic [31:0]            i_rt_value;
   logic [NB_EX-1:0]       o_ex_ctrl;
   logic [NB_MEM-1:0]      o_mem_ctrl;
   logic [NB_WB-1:0]       o_wb_ctrl;
   logic [31:0]            o_pc;
   logic                   o_flush;
   logic                   o_branch;
   logic                   o_jump_reg;
   logic                   o_jump_imm;
   logic [NB_J_ADDR-1:0]   o_jump_addr;
   logic [NB_IMM-1:0]      o_imm;

   integer      seed = 32'hce77d5ba;
   int          errors;
   int          checks;
   logic [31:0] exp_pc;

   decode_stage decode_stage_inst (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instruction (i_instruction),
      .i_pc          (i_pc),
      .i_rs_value    (i_rs_value),
      .i_rt_value    (i_rt_value),
      .o_ex_ctrl     (o_ex_ctrl),
      .o_mem_ctrl    (o_mem_ctrl),
      .o_wb_ctrl     (o_wb_ctrl),
      .o_pc          (o_pc),
      .o_flush       (o_flush),
      .o_branch      (o_branch),
      .o_jump_reg    (o_jump_reg),
      .o_jump_imm    (o_jump_imm),
      .o_jump_addr   (o_jump_addr),
      .o_imm         (o_imm)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   function automatic logic [NB_EX-1:0] ex_word(input logic [NB_ALUOP-1:0] alu,
                                                input logic b_i, input logic uns);
      ex_word = {alu, b_i, uns};
   endfunction

   function automatic logic [NB_WB-1:0] wb_word(input logic [NB_REG_ADDR-1:0] dest,
                                                input logic we, input logic mem_alu,
                                                input logic data_pc);
      wb_word = {dest, we, mem_alu, data_pc};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // Called at a falling edge, outputs checked once they settle
   task automatic present(input logic [31:0] instr, input logic [31:0] rs_val,
                          input logic [31:0] rt_val);
      i_instruction = instr;
      i_pc          = rand32();
      i_rs_value    = rs_val;
      i_rt_value    = rt_val;
      exp_pc        = i_pc;
      #1;
   endtask

   task automatic next_edge();
      @(negedge i_clk);
      check_val("o_pc", o_pc, exp_pc);
   endtask

   task automatic check_registered_zero();
      check_val("o_ex_ctrl", 32'(o_ex_ctrl), 32'd0);
      check_val("o_mem_ctrl", 32'(o_mem_ctrl), 32'd0);
      check_val("o_wb_ctrl", 32'(o_wb_ctrl), 32'd0);
      check_val("o_pc", o_pc, 32'd0);
      check_val("o_flush", 32'(o_flush), 32'd0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////
   task automatic test_reset();
      logic [31:0] r;
      i_rst = 1'b1;
      for (int k = 0; k < 8; k++) begin
         r = rand32();
         // Decodes that would load nonzero words without the reset
         case (k % 3)
            0:       i_instruction = {OP_JAL, r[25:0]};
            1:       i_instruction = {OP_LW, r[4:0], r[9:5], r[31:16]};
            default: i_instruction = {OP_LUI, r[4:0], r[9:5], r[31:16]};
         endcase
         i_pc = rand32() | 32'd1;
         @(negedge i_clk);
         check_registered_zero();
      end
      // Undefined opcode decodes to all-zero words
      i_rst         = 1'b0;
      i_instruction = {6'b111111, 26'd0};
      i_pc          = '0;
      @(negedge i_clk);
      check_registered_zero();
   endtask

   task automatic test_load_store();
      logic [31:0]       r;
      logic [NB_IMM-1:0] imm;
      logic [4:0]        rs;
      logic [4:0]        rt;
      logic              is_load;
      logic              uns;
      for (int k = 0; k < 9; k++) begin
         r       = rand32();
         rs      = r[4:0];
         rt      = r[9:5];
         imm     = r[31:16];
         is_load = (k < 6);
         uns     = (k >= 3 && k < 6);
         present({MEM_OPS[k], rs, rt, imm}, rand32(), rand32());
         check_val("o_imm", 32'(o_imm), 32'(imm));
         next_edge();
         check_val("o_mem_ctrl", 32'(o_mem_ctrl),
                   32'({is_load, !is_load, uns, MEM_SIZES[k]}));
         check_val("o_wb_ctrl reg write", 32'(o_wb_ctrl[WB_REG_WE]), 32'(is_load));
         if (is_load) begin
            check_val("o_wb_ctrl dest", 32'(o_wb_ctrl[WB_DEST_LSB +: NB_REG_ADDR]), 32'(rt));
            check_val("o_wb_ctrl mem_alu", 32'(o_wb_ctrl[WB_MEM_ALU]), 32'd0);
         end
         check_val("o_flush", 32'(o_flush), 32'd0);
      end
   endtask

   task automatic test_r_alu();
      logic [31:0] r;
      for (int k = 0; k < 13; k++) begin
         r = rand32();
         present({OP_R_TYPE, r[4:0], r[9:5], r[14:10], r[19:15], R_FUNCTS[k]}, r, ~r);
         check_val("o_jump_reg", 32'(o_jump_reg), 32'd0);
         next_edge();
         check_val("o_ex_ctrl", 32'(o_ex_ctrl), 32'(ex_word(R_ALUOPS[k], 1'b0, 1'b0)));
         check_val("o_mem_ctrl", 32'(o_mem_ctrl), 32'd0);
         check_val("o_wb_ctrl", 32'(o_wb_ctrl), 32'(wb_word(r[14:10], 1'b1, 1'b1, 1'b0)));
         check_val("o_flush", 32'(o_flush), 32'd0);
      end
   endtask

   task automatic test_i_alu();
      logic [31:0] r;
      logic        uns;
      for (int k = 0; k < 6; k++) begin
         r   = rand32();
         uns = (k >= 1 && k <= 4);
         present({I_OPS[k], r[4:0], r[9:5], r[31:16]}, rand32(), rand32());
         check_val("o_imm", 32'(o_imm), 32'(r[31:16]));
         next_edge();
         check_val("o_ex_ctrl", 32'(o_ex_ctrl), 32'(ex_word(I_ALUOPS[k], 1'b1, uns)));
         check_val("o_mem_ctrl", 32'(o_mem_ctrl), 32'd0);
         check_val("o_wb_ctrl", 32'(o_wb_ctrl), 32'(wb_word(r[9:5], 1'b1, 1'b1, 1'b0)));
      end
   endtask

   task automatic test_branch();
      logic [31:0] r;
      logic [31:0] a;
      logic [31:0] b;
      logic        taken;
      for (int k = 0; k < 4; k++) begin
         r = rand32();
         a = rand32();
         // Odd passes use equal operands
         b = k[0] ? a : rand32();
         taken = (k < 2) ? (a == b) : (a != b);
         present({(k < 2) ? OP_BEQ : OP_BNE, r[4:0], r[9:5], r[31:16]}, a, b);
         check_val("o_branch", 32'(o_branch), 32'd1);
         check_val("o_jump_imm", 32'(o_jump_imm), 32'd0);
         check_val("o_jump_reg", 32'(o_jump_reg), 32'd0);
         next_edge();
         check_val("o_flush", 32'(o_flush), 32'(taken));
      end
   endtask

   task automatic test_jump();
      logic [31:0] r;
      for (int k = 0; k < 2; k++) begin
         r = rand32();
         present({(k == 0) ? OP_J : OP_JAL, r[25:0]}, rand32(), rand32());
         check_val("o_jump_imm", 32'(o_jump_imm), 32'd1);
         check_val("o_jump_addr", 32'(o_jump_addr), 32'(r[25:0]));
         check_val("o_branch", 32'(o_branch), 32'd0);
         next_edge();
         check_val("o_flush", 32'(o_flush), 32'd1);
         if (k == 1) begin
            check_val("o_wb_ctrl dest", 32'(o_wb_ctrl[WB_DEST_LSB +: NB_REG_ADDR]),
                      32'(LINK_REG_ADDR));
            check_val("o_wb_ctrl reg write", 32'(o_wb_ctrl[WB_REG_WE]), 32'd1);
            check_val("o_wb_ctrl data_pc", 32'(o_wb_ctrl[WB_DATA_PC]), 32'd1);
         end
      end
      for (int k = 0; k < 2; k++) begin
         r = rand32();
         present({OP_R_TYPE, r[4:0], 5'd0, r[14:10], 5'd0, (k == 0) ? FUNCT_JR : FUNCT_JALR},
                 rand32(), rand32());
         check_val("o_jump_reg", 32'(o_jump_reg), 32'd1);
         next_edge();
         check_val("o_flush", 32'(o_flush), 32'd1);
         if (k == 1) begin
            check_val("o_wb_ctrl dest", 32'(o_wb_ctrl[WB_DEST_LSB +: NB_REG_ADDR]),
                      32'(LINK_REG_ADDR));
            check_val("o_wb_ctrl reg write", 32'(o_wb_ctrl[WB_REG_WE]), 32'd1);
            check_val("o_wb_ctrl data_pc", 32'(o_wb_ctrl[WB_DATA_PC]), 32'd1);
         end
      end
      // JR funct bits under a non R-type opcode
      r = rand32();
      present({OP_ADDI, r[4:0], r[9:5], r[25:16], FUNCT_JR}, rand32(), rand32());
      check_val("o_jump_reg", 32'(o_jump_reg), 32'd0);
      next_edge();
      check_val("o_flush", 32'(o_flush), 32'd0);
   endtask

   initial begin
      errors        = 0;
      checks        = 0;
      i_rst         = 1'b1;
      i_instruction = {6'b111111, 26'd0};
      i_pc          = '0;
      i_rs_value    = '0;
      i_rt_value    = '0;
      exp_pc        = '0;
      test_reset();
      test_load_store();
      test_r_alu();
      test_i_alu();
      test_branch();
      test_jump();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT);
      $display("Timeout: tests still running after %0d time units", TIMEOUT);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
decode_pkg.sv
funct_decoder.sv
control_decoder.sv
branch_resolver.sv
id_ex_register.sv
decode_stage.sv
decode_props.sv
tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_decode_stage -f src.f -o sim_decode
./obj_dir/sim_decode | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
   echo "Run finished without errors"
else
   echo "Run reported errors, see sim.log"
   exit 1
fi
